// ==== cache_cfg_pkg.sv ====
/* icache tag geometry
   way/bank counts and how a line address splits into tag, set and bank */
package cache_cfg_pkg;

  // organisation
  localparam int unsigned NUM_WAYS  = 4;
  localparam int unsigned NUM_BANKS = 4;

  // address fields, low to high: bank, set, tag
  localparam int unsigned BANK_BITS = $clog2(NUM_BANKS);  // 2
  localparam int unsigned SET_BITS  = 6;                  // sets per bank, log2
  localparam int unsigned TAG_BITS  = 20;

  localparam int unsigned LINE_ADDR_BITS = TAG_BITS + SET_BITS + BANK_BITS;  // 28

  // lsb of each field inside the line address
  // bank sits at the bottom so sequential lines spread over banks
  localparam int unsigned BANK_LSB = 0;
  localparam int unsigned SET_LSB  = BANK_LSB + BANK_BITS;
  localparam int unsigned TAG_LSB  = SET_LSB + SET_BITS;

endpackage : cache_cfg_pkg

// ==== tag_types_pkg.sv ====
/* icache tag lookup types
   write opcode plus request, bank control, lookup record and response structs */
package tag_types_pkg;

  // refill opcode
  typedef enum logic {
    TAG_OP_FILL  = 1'b0,  // write tag, set valid
    TAG_OP_INVAL = 1'b1   // clear valid
  } tag_op_e;

  // two-line fetch lookup, single-cycle strobe (57b)
  typedef struct packed {
    logic                                     valid;
    logic [cache_cfg_pkg::LINE_ADDR_BITS-1:0] addr_a;
    logic [cache_cfg_pkg::LINE_ADDR_BITS-1:0] addr_b;
  } lookup_req_t;

  // refill write request (34b)
  typedef struct packed {
    logic                                     valid;
    tag_op_e                                  op;
    logic [cache_cfg_pkg::NUM_WAYS-1:0]       way_mask;
    logic [cache_cfg_pkg::LINE_ADDR_BITS-1:0] addr;
  } tag_wr_req_t;

  // per bank sram control, shared by all ways of the bank (28b)
  typedef struct packed {
    logic                               we;
    logic [cache_cfg_pkg::SET_BITS-1:0] addr;
    logic [cache_cfg_pkg::TAG_BITS:0]   wdata;  // {tag, valid}
  } bank_ctrl_t;

  // registered lookup record, one per port (23b)
  typedef struct packed {
    logic                                served;  // port won its bank
    logic [cache_cfg_pkg::BANK_BITS-1:0] bank;
    logic [cache_cfg_pkg::TAG_BITS-1:0]  tag;     // compare tag
  } lookup_meta_t;

  // per port result (6b)
  typedef struct packed {
    logic                               ok;   // lookup was served
    logic                               hit;
    logic [cache_cfg_pkg::NUM_WAYS-1:0] way;  // one-hot hit way
  } lookup_resp_t;

endpackage : tag_types_pkg

// ==== tag_sram.sv ====
/* single-port tag sram, one way of one bank
   sync read, tag field in the array, valid bits in resettable flops */
`timescale 1ns/1ps

module tag_sram #(
  parameter int unsigned ADDR_BITS = 6,
  parameter int unsigned DATA_BITS = 21   // {tag, valid}
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 we_i,
  input  logic [ADDR_BITS-1:0] addr_i,
  input  logic [DATA_BITS-1:0] wdata_i,
  output logic [DATA_BITS-1:0] rdata_o
);

  localparam int unsigned DEPTH = 2 ** ADDR_BITS;

  logic [DATA_BITS-1:1] tag_mem [DEPTH];  // tag bits only
  logic [DEPTH-1:0]     valid_q;          // one valid per entry
  logic [DATA_BITS-1:1] rtag_q;
  logic                 rvalid_q;

  // tag array, read-before-write gives old word on collision
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      tag_mem[addr_i] <= wdata_i[DATA_BITS-1:1];
    end
    rtag_q <= tag_mem[addr_i];
  end

  // valid bits, cleared by reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= '0;
      rvalid_q <= 1'b0;
    end else begin
      if (we_i) begin
        valid_q[addr_i] <= wdata_i[0];
      end
      rvalid_q <= valid_q[addr_i];  // old value, same as the tag
    end
  end

  assign rdata_o = {rtag_q, rvalid_q};

endmodule : tag_sram

// ==== tag_bank_arbiter.sv ====
/* tag bank arbiter
   routes each single-port bank to write, then A, then B; records who got served */
`timescale 1ns/1ps

module tag_bank_arbiter (
  input  logic                                                       clk_i,
  input  logic                                                       reset_i,
  input  tag_types_pkg::lookup_req_t                                 lookup_i,
  input  tag_types_pkg::tag_wr_req_t                                 wr_i,
  output tag_types_pkg::bank_ctrl_t [cache_cfg_pkg::NUM_BANKS-1:0]   bank_ctrl_o,
  output logic [cache_cfg_pkg::NUM_WAYS-1:0]                         way_we_o,
  output tag_types_pkg::lookup_meta_t                                meta_a_o,
  output tag_types_pkg::lookup_meta_t                                meta_b_o,
  output logic                                                       meta_valid_o
);

  localparam int unsigned BANK_BITS = cache_cfg_pkg::BANK_BITS;
  localparam int unsigned SET_BITS  = cache_cfg_pkg::SET_BITS;
  localparam int unsigned TAG_BITS  = cache_cfg_pkg::TAG_BITS;
  localparam int unsigned SET_LSB   = cache_cfg_pkg::SET_LSB;
  localparam int unsigned TAG_LSB   = cache_cfg_pkg::TAG_LSB;

  // address fields
  logic [BANK_BITS-1:0] bank_a, bank_b, bank_w;
  logic [SET_BITS-1:0]  set_a, set_b, set_w;
  logic [TAG_BITS-1:0]  tag_a, tag_b, tag_w;

  logic                 wvalid;         // valid bit written by the refill
  logic                 grant_a, grant_b;

  // registered lookup record
  logic                 served_a_q, served_b_q;
  logic [BANK_BITS-1:0] bank_a_q, bank_b_q;
  logic [TAG_BITS-1:0]  tag_a_q, tag_b_q;

  assign bank_a = lookup_i.addr_a[cache_cfg_pkg::BANK_LSB +: BANK_BITS];
  assign set_a  = lookup_i.addr_a[SET_LSB +: SET_BITS];
  assign tag_a  = lookup_i.addr_a[TAG_LSB +: TAG_BITS];
  assign bank_b = lookup_i.addr_b[cache_cfg_pkg::BANK_LSB +: BANK_BITS];
  assign set_b  = lookup_i.addr_b[SET_LSB +: SET_BITS];
  assign tag_b  = lookup_i.addr_b[TAG_LSB +: TAG_BITS];
  assign bank_w = wr_i.addr[cache_cfg_pkg::BANK_LSB +: BANK_BITS];
  assign set_w  = wr_i.addr[SET_LSB +: SET_BITS];
  assign tag_w  = wr_i.addr[TAG_LSB +: TAG_BITS];

  assign wvalid = (wr_i.op == tag_types_pkg::TAG_OP_FILL);  // inval writes valid=0

  // write always wins; B also yields to A on a shared bank
  assign grant_a = lookup_i.valid && !(wr_i.valid && (bank_w == bank_a));
  assign grant_b = lookup_i.valid && !(wr_i.valid && (bank_w == bank_b))
                   && (bank_b != bank_a);

  assign way_we_o = wr_i.valid ? wr_i.way_mask : '0;  // qualified with bank we at the top

  // per bank address mux, idle banks park at set 0
  always_comb begin
    for (int b = 0; b < cache_cfg_pkg::NUM_BANKS; b++) begin
      bank_ctrl_o[b] = '0;
      if (wr_i.valid && (bank_w == BANK_BITS'(b))) begin
        bank_ctrl_o[b].we    = 1'b1;
        bank_ctrl_o[b].addr  = set_w;
        bank_ctrl_o[b].wdata = {tag_w, wvalid};
      end else if (grant_a && (bank_a == BANK_BITS'(b))) begin
        bank_ctrl_o[b].addr = set_a;   // read for A
      end else if (grant_b && (bank_b == BANK_BITS'(b))) begin
        bank_ctrl_o[b].addr = set_b;   // read for B
      end
    end
  end

  // control flags, same edge as the sram read
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      meta_valid_o <= 1'b0;
      served_a_q   <= 1'b0;
      served_b_q   <= 1'b0;
    end else begin
      meta_valid_o <= lookup_i.valid;
      served_a_q   <= grant_a;
      served_b_q   <= grant_b;
    end
  end

  // payload, only meaningful while served
  always_ff @(posedge clk_i) begin
    bank_a_q <= bank_a;
    bank_b_q <= bank_b;
    tag_a_q  <= tag_a;
    tag_b_q  <= tag_b;
  end

  assign meta_a_o = '{served: served_a_q, bank: bank_a_q, tag: tag_a_q};
  assign meta_b_o = '{served: served_b_q, bank: bank_b_q, tag: tag_b_q};

endmodule : tag_bank_arbiter

// ==== tag_hit_compare.sv ====
/* tag hit stage
   picks each way's word from the recorded bank and compares it per port */
`timescale 1ns/1ps

module tag_hit_compare (
  input  tag_types_pkg::lookup_meta_t meta_a_i,
  input  tag_types_pkg::lookup_meta_t meta_b_i,
  input  logic                        meta_valid_i,
  input  logic [cache_cfg_pkg::NUM_WAYS-1:0][cache_cfg_pkg::NUM_BANKS-1:0]
               [cache_cfg_pkg::TAG_BITS:0] rd_i,  // {tag, valid} per way, bank
  output logic                        resp_valid_o,
  output tag_types_pkg::lookup_resp_t resp_a_o,
  output tag_types_pkg::lookup_resp_t resp_b_o
);

  localparam int unsigned NUM_WAYS  = cache_cfg_pkg::NUM_WAYS;
  localparam int unsigned NUM_BANKS = cache_cfg_pkg::NUM_BANKS;
  localparam int unsigned TAG_BITS  = cache_cfg_pkg::TAG_BITS;

  // one port's compare; both ports share it
  function automatic tag_types_pkg::lookup_resp_t port_resp(
    input tag_types_pkg::lookup_meta_t                             meta,
    input logic [NUM_WAYS-1:0][NUM_BANKS-1:0][TAG_BITS:0]          rd
  );
    logic [TAG_BITS:0]           word;
    logic [NUM_WAYS-1:0]         match;
    tag_types_pkg::lookup_resp_t resp;

    for (int w = 0; w < NUM_WAYS; w++) begin
      word     = rd[w][meta.bank];                              // bank mux
      match[w] = word[0] && (word[TAG_BITS:1] == meta.tag);     // valid and tag equal
    end

    resp.ok  = meta.served;            // lost arbitration -> not ok
    resp.hit = meta.served && (|match);
    // a multi-way fill can leave duplicate tags,
    // keep only the lowest matching way so the result stays one-hot
    resp.way = meta.served ? (match & (~match + NUM_WAYS'(1))) : '0;
    return resp;
  endfunction

  assign resp_valid_o = meta_valid_i;  // one cycle after the strobe
  assign resp_a_o     = port_resp(meta_a_i, rd_i);
  assign resp_b_o     = port_resp(meta_b_i, rd_i);

endmodule : tag_hit_compare

// ==== icache_tag_lookup.sv ====
/* icache tag lookup top
   bank arbiter, ways x banks grid of tag srams and the hit compare stage */
`timescale 1ns/1ps

module icache_tag_lookup (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  tag_types_pkg::lookup_req_t  lookup_i,   // two-line lookup strobe
  input  tag_types_pkg::tag_wr_req_t  wr_i,       // refill write strobe
  output logic                        resp_valid_o,
  output tag_types_pkg::lookup_resp_t resp_a_o,
  output tag_types_pkg::lookup_resp_t resp_b_o
);

  localparam int unsigned NUM_WAYS  = cache_cfg_pkg::NUM_WAYS;
  localparam int unsigned NUM_BANKS = cache_cfg_pkg::NUM_BANKS;

  // sram geometry handed down to every instance
  localparam int unsigned SRAM_ADDR_BITS = cache_cfg_pkg::SET_BITS;
  localparam int unsigned SRAM_DATA_BITS = cache_cfg_pkg::TAG_BITS + 1;  // tag + valid

  tag_types_pkg::bank_ctrl_t [NUM_BANKS-1:0] bank_ctrl;
  logic [NUM_WAYS-1:0]                       way_we;

  // read words, [way][bank]
  logic [NUM_WAYS-1:0][NUM_BANKS-1:0][SRAM_DATA_BITS-1:0] sram_rd;

  tag_types_pkg::lookup_meta_t meta_a;
  tag_types_pkg::lookup_meta_t meta_b;
  logic                        meta_valid;

  // bank arbitration, meta registered alongside the sram read
  tag_bank_arbiter i_tag_bank_arbiter (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .lookup_i     (lookup_i),
    .wr_i         (wr_i),
    .bank_ctrl_o  (bank_ctrl),
    .way_we_o     (way_we),
    .meta_a_o     (meta_a),
    .meta_b_o     (meta_b),
    .meta_valid_o (meta_valid)
  );

  // one sram per way and bank; a bank's ways share addr and wdata
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      logic sram_we;

      assign sram_we = bank_ctrl[b].we & way_we[w];  // bank selected and way in mask

      tag_sram #(
        .ADDR_BITS (SRAM_ADDR_BITS),
        .DATA_BITS (SRAM_DATA_BITS)
      ) i_tag_sram (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .we_i    (sram_we),
        .addr_i  (bank_ctrl[b].addr),
        .wdata_i (bank_ctrl[b].wdata),
        .rdata_o (sram_rd[w][b])
      );
    end
  end

  // compare against the registered tags
  tag_hit_compare i_tag_hit_compare (
    .meta_a_i     (meta_a),
    .meta_b_i     (meta_b),
    .meta_valid_i (meta_valid),
    .rd_i         (sram_rd),
    .resp_valid_o (resp_valid_o),
    .resp_a_o     (resp_a_o),
    .resp_b_o     (resp_b_o)
  );

endmodule : icache_tag_lookup

// ==== tb_icache_tag_lookup_asserts.sv ====
/* icache tag lookup assertions
   response latency, one-hot hit way, hit only when served */
`timescale 1ns/1ps

module tb_icache_tag_lookup_asserts (
  input logic                        clk_i,
  input logic                        reset_i,
  input tag_types_pkg::lookup_req_t  lookup_i,
  input logic                        resp_valid_i,
  input tag_types_pkg::lookup_resp_t resp_a_i,
  input tag_types_pkg::lookup_resp_t resp_b_i
);

  int fail_cnt = 0;  // failed assertion count

  // response one cycle after the strobe, skip the first cycle out of reset
  a_resp_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    !$past(reset_i) |-> (resp_valid_i == $past(lookup_i.valid)))
    else begin
      $error("resp_valid_o does not follow the lookup strobe by one cycle");
      fail_cnt++;
    end

  a_way_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(resp_a_i.way))
    else begin
      $error("port a hit way has more than one bit set");
      fail_cnt++;
    end

  a_way_onehot_b: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(resp_b_i.way))
    else begin
      $error("port b hit way has more than one bit set");
      fail_cnt++;
    end

  // a port that lost its bank cannot hit
  a_hit_ok_a: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_a_i.hit |-> resp_a_i.ok)
    else begin
      $error("port a reports a hit without being served");
      fail_cnt++;
    end

  a_hit_ok_b: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_b_i.hit |-> resp_b_i.ok)
    else begin
      $error("port b reports a hit without being served");
      fail_cnt++;
    end

endmodule : tb_icache_tag_lookup_asserts

bind icache_tag_lookup tb_icache_tag_lookup_asserts i_tb_icache_tag_lookup_asserts (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .lookup_i     (lookup_i),
  .resp_valid_i (resp_valid_o),
  .resp_a_i     (resp_a_o),
  .resp_b_i     (resp_b_o)
);

// ==== tb_icache_tag_lookup.sv ====
/* icache tag lookup testbench
   directed table, then seeded random traffic against a reference tag model */
`timescale 1ns/1ps

module tb_icache_tag_lookup;

  localparam int unsigned NUM_WAYS  = cache_cfg_pkg::NUM_WAYS;
  localparam int unsigned NUM_BANKS = cache_cfg_pkg::NUM_BANKS;
  localparam int unsigned BANK_BITS = cache_cfg_pkg::BANK_BITS;
  localparam int unsigned SET_BITS  = cache_cfg_pkg::SET_BITS;
  localparam int unsigned TAG_BITS  = cache_cfg_pkg::TAG_BITS;
  localparam int unsigned NUM_SETS  = 2 ** SET_BITS;

  localparam int NUM_ROWS       = 19;
  localparam int NUM_RAND       = 200;
  localparam int RESET_CYCLES   = 3;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS + NUM_RAND + 1 + 50;  // +1 flush

  // one cycle of stimulus plus what each port should answer
  typedef struct packed {
    tag_types_pkg::tag_wr_req_t  wr;
    tag_types_pkg::lookup_req_t  lk;
    tag_types_pkg::lookup_resp_t exp_a;
    tag_types_pkg::lookup_resp_t exp_b;
  } row_t;

  localparam tag_types_pkg::lookup_resp_t RSP_MISS = 6'b10_0000;  // served, no hit
  localparam tag_types_pkg::lookup_resp_t RSP_LOST = 6'b00_0000;  // bank taken by someone else

  localparam logic [TAG_BITS-1:0] TAG_1 = 20'h12345;
  localparam logic [TAG_BITS-1:0] TAG_2 = 20'h0abcd;
  localparam logic [TAG_BITS-1:0] TAG_3 = 20'h00777;
  localparam logic [TAG_BITS-1:0] TAG_4 = 20'hfedcb;
  localparam logic [TAG_BITS-1:0] TAG_5 = 20'h00042;

  logic                        clk;
  logic                        reset;
  tag_types_pkg::lookup_req_t  lookup;
  tag_types_pkg::tag_wr_req_t  wr;
  logic                        resp_valid;
  tag_types_pkg::lookup_resp_t resp_a;
  tag_types_pkg::lookup_resp_t resp_b;

  row_t table_q[$];
  row_t pend;         // row whose response is due on the next check
  int   pend_step;
  int   step_no;
  int   err_cnt;
  int   cycle_cnt;
  int   seed = 32'h3b01;

  // reference tag store, [way][bank][set]
  logic [TAG_BITS-1:0] ref_tag   [NUM_WAYS][NUM_BANKS][NUM_SETS];
  logic                ref_valid [NUM_WAYS][NUM_BANKS][NUM_SETS];

  icache_tag_lookup i_icache_tag_lookup (
    .clk_i        (clk),
    .reset_i      (reset),
    .lookup_i     (lookup),
    .wr_i         (wr),
    .resp_valid_o (resp_valid),
    .resp_a_o     (resp_a),
    .resp_b_o     (resp_b)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns
  end

  // run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  // line address is tag, set, bank from high to low
  function automatic logic [cache_cfg_pkg::LINE_ADDR_BITS-1:0] line_addr(
    input logic [TAG_BITS-1:0] tag, input logic [SET_BITS-1:0] set,
    input logic [BANK_BITS-1:0] bank);
    return {tag, set, bank};
  endfunction

  function automatic tag_types_pkg::lookup_resp_t hit_in(input logic [NUM_WAYS-1:0] way);
    return {1'b1, 1'b1, way};
  endfunction

  function automatic tag_types_pkg::tag_wr_req_t wr_req(input tag_types_pkg::tag_op_e op,
    input logic [NUM_WAYS-1:0] mask, input logic [cache_cfg_pkg::LINE_ADDR_BITS-1:0] addr);
    return '{valid: 1'b1, op: op, way_mask: mask, addr: addr};
  endfunction

  function automatic tag_types_pkg::lookup_req_t lk_req(
    input logic [cache_cfg_pkg::LINE_ADDR_BITS-1:0] addr_a,
    input logic [cache_cfg_pkg::LINE_ADDR_BITS-1:0] addr_b);
    return '{valid: 1'b1, addr_a: addr_a, addr_b: addr_b};
  endfunction

  task automatic add_row(input tag_types_pkg::tag_wr_req_t w, input tag_types_pkg::lookup_req_t l,
    input tag_types_pkg::lookup_resp_t ea, input tag_types_pkg::lookup_resp_t eb);
    row_t r;
    r.wr    = w;
    r.lk    = l;
    r.exp_a = ea;
    r.exp_b = eb;
    table_q.push_back(r);
  endtask

  task automatic build_table();
    // empty cache, every served lookup misses
    add_row('0, lk_req(line_addr(TAG_1, 5, 0), line_addr(TAG_1, 5, 1)), RSP_MISS, RSP_MISS);
    add_row('0, lk_req(line_addr(TAG_2, 63, 2), line_addr(TAG_2, 0, 3)), RSP_MISS, RSP_MISS);
    // fill way 2 of set 5 in banks 0 and 1
    add_row(wr_req(tag_types_pkg::TAG_OP_FILL, 4'b0100, line_addr(TAG_1, 5, 0)), '0,
            RSP_LOST, RSP_LOST);
    add_row(wr_req(tag_types_pkg::TAG_OP_FILL, 4'b0100, line_addr(TAG_1, 5, 1)), '0,
            RSP_LOST, RSP_LOST);
    add_row('0, lk_req(line_addr(TAG_1, 5, 0), line_addr(TAG_1, 5, 1)),
            hit_in(4'b0100), hit_in(4'b0100));
    add_row('0, lk_req(line_addr(TAG_2, 5, 0), line_addr(TAG_1, 6, 1)), RSP_MISS, RSP_MISS);
    // other ways of bank 0 set 5
    add_row(wr_req(tag_types_pkg::TAG_OP_FILL, 4'b0001, line_addr(TAG_2, 5, 0)), '0,
            RSP_LOST, RSP_LOST);
    add_row(wr_req(tag_types_pkg::TAG_OP_FILL, 4'b1000, line_addr(TAG_3, 5, 0)), '0,
            RSP_LOST, RSP_LOST);
    add_row('0, lk_req(line_addr(TAG_2, 5, 0), line_addr(TAG_1, 5, 1)),
            hit_in(4'b0001), hit_in(4'b0100));
    // invalidate way 2 in bank 0 only
    add_row(wr_req(tag_types_pkg::TAG_OP_INVAL, 4'b0100, line_addr(TAG_1, 5, 0)), '0,
            RSP_LOST, RSP_LOST);
    add_row('0, lk_req(line_addr(TAG_1, 5, 0), line_addr(TAG_1, 5, 1)),
            RSP_MISS, hit_in(4'b0100));
    add_row('0, lk_req(line_addr(TAG_3, 5, 0), line_addr(TAG_2, 5, 1)),
            hit_in(4'b1000), RSP_MISS);
    add_row('0, lk_req(line_addr(TAG_2, 5, 0), line_addr(TAG_3, 5, 0)),  // same bank, B yields
            hit_in(4'b0001), RSP_LOST);
    // write steals A's bank, B elsewhere unaffected
    add_row(wr_req(tag_types_pkg::TAG_OP_FILL, 4'b0010, line_addr(TAG_4, 9, 3)),
            lk_req(line_addr(TAG_4, 9, 3), line_addr(TAG_1, 5, 1)), RSP_LOST, hit_in(4'b0100));
    add_row('0, lk_req(line_addr(TAG_4, 9, 3), line_addr(TAG_4, 9, 2)),
            hit_in(4'b0010), RSP_MISS);
    add_row(wr_req(tag_types_pkg::TAG_OP_FILL, 4'b0001, line_addr(TAG_5, 2, 2)),
            lk_req(line_addr(TAG_4, 9, 3), line_addr(TAG_5, 2, 2)), hit_in(4'b0010), RSP_LOST);
    add_row('0, lk_req(line_addr(TAG_1, 5, 1), line_addr(TAG_5, 2, 2)),
            hit_in(4'b0100), hit_in(4'b0001));
    add_row(wr_req(tag_types_pkg::TAG_OP_INVAL, 4'b0010, line_addr(TAG_4, 9, 3)),
            lk_req(line_addr(TAG_2, 5, 0), line_addr(TAG_4, 9, 1)), hit_in(4'b0001), RSP_MISS);
    add_row('0, lk_req(line_addr(TAG_4, 9, 3), line_addr(TAG_5, 2, 2)),
            RSP_MISS, hit_in(4'b0001));
  endtask

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL @%0t: step %0d %s got %0h, expected %0h", $time, pend_step, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    compare_value(32'(resp_valid), 32'(pend.lk.valid), "resp_valid");
    if (pend.lk.valid) begin  // payload only defined for a real lookup
      compare_value(32'(resp_a.ok), 32'(pend.exp_a.ok), "port a ok");
      compare_value(32'(resp_a.hit), 32'(pend.exp_a.hit), "port a hit");
      compare_value(32'(resp_a.way), 32'(pend.exp_a.way), "port a way");
      compare_value(32'(resp_b.ok), 32'(pend.exp_b.ok), "port b ok");
      compare_value(32'(resp_b.hit), 32'(pend.exp_b.hit), "port b hit");
      compare_value(32'(resp_b.way), 32'(pend.exp_b.way), "port b way");
    end
  endtask

  task automatic apply_write(input tag_types_pkg::tag_wr_req_t w);
    logic [BANK_BITS-1:0] bank;
    logic [SET_BITS-1:0]  set;
    bank = w.addr[BANK_BITS-1:0];
    set  = w.addr[BANK_BITS +: SET_BITS];
    if (w.valid) begin
      for (int k = 0; k < NUM_WAYS; k++) begin
        if (w.way_mask[k]) begin
          ref_tag[k][bank][set]   = w.addr[BANK_BITS + SET_BITS +: TAG_BITS];
          ref_valid[k][bank][set] = (w.op == tag_types_pkg::TAG_OP_FILL);
        end
      end
    end
  endtask

  function automatic tag_types_pkg::lookup_resp_t expect_port(input logic served,
    input logic [cache_cfg_pkg::LINE_ADDR_BITS-1:0] addr);
    logic [BANK_BITS-1:0]        bank;
    logic [SET_BITS-1:0]         set;
    tag_types_pkg::lookup_resp_t r;
    bank = addr[BANK_BITS-1:0];
    set  = addr[BANK_BITS +: SET_BITS];
    r    = '0;
    if (served) begin
      r.ok = 1'b1;
      for (int k = NUM_WAYS - 1; k >= 0; k--) begin  // lowest matching way wins
        if (ref_valid[k][bank][set] &&
            ref_tag[k][bank][set] == addr[BANK_BITS + SET_BITS +: TAG_BITS]) begin
          r.way    = '0;
          r.way[k] = 1'b1;
        end
      end
      r.hit = |r.way;
    end
    return r;
  endfunction

  // write, then A, then B per bank
  function automatic row_t predict_row(input tag_types_pkg::tag_wr_req_t w,
    input tag_types_pkg::lookup_req_t l);
    logic [BANK_BITS-1:0] bw, ba, bb;
    row_t r;
    bw      = w.addr[BANK_BITS-1:0];
    ba      = l.addr_a[BANK_BITS-1:0];
    bb      = l.addr_b[BANK_BITS-1:0];
    r.wr    = w;
    r.lk    = l;
    r.exp_a = expect_port(l.valid && !(w.valid && bw == ba), l.addr_a);
    r.exp_b = expect_port(l.valid && !(w.valid && bw == bb) && (bb != ba), l.addr_b);
    return r;
  endfunction

  // small tag and set pools so random lookups do hit
  task automatic rand_addr(output logic [cache_cfg_pkg::LINE_ADDR_BITS-1:0] addr);
    logic [31:0] rnd;
    rnd  = $random(seed);
    addr = line_addr({16'h5a5a, 2'b00, rnd[1:0]}, {4'b0000, rnd[3:2]}, rnd[5:4]);
  endtask

  // drive one row, then check the response of the row before
  task automatic step(input row_t r);
    @(posedge clk);
    lookup <= r.lk;
    wr     <= r.wr;
    apply_write(r.wr);  // visible to the next row's prediction
    @(negedge clk);
    check_outputs();
    pend      = r;
    pend_step = step_no;
    step_no++;
  endtask

  initial begin
    tag_types_pkg::tag_wr_req_t rw;
    tag_types_pkg::lookup_req_t rl;
    logic [31:0]                rnd;
    int                         asrt_fails;
    reset     = 1'b1;
    lookup    = '0;
    wr        = '0;
    pend      = '0;
    pend_step = 0;
    step_no   = 0;
    err_cnt   = 0;
    ref_valid = '{default: '0};
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < table_q.size(); i++) begin
      step(table_q[i]);
    end
    for (int n = 0; n < NUM_RAND; n++) begin
      rnd         = $random(seed);
      rl.valid    = (rnd[1:0] != 2'b00);  // 3 of 4 cycles
      rw.valid    = (rnd[4:2] < 3'd3);
      rw.op       = (rnd[6:5] == 2'b11) ? tag_types_pkg::TAG_OP_INVAL : tag_types_pkg::TAG_OP_FILL;
      rw.way_mask = 4'b0001 << rnd[8:7];
      rand_addr(rw.addr);
      rand_addr(rl.addr_a);
      rand_addr(rl.addr_b);
      step(predict_row(rw, rl));
    end
    step('0);  // flush the last response
    asrt_fails = i_icache_tag_lookup.i_tb_icache_tag_lookup_asserts.fail_cnt;
    $display("errors: %0d check, %0d assertion in %0d steps", err_cnt, asrt_fails, step_no);
    if (err_cnt == 0 && asrt_fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tb_icache_tag_lookup

// ==== icache_tag_lookup.f ====
cache_cfg_pkg.sv
tag_types_pkg.sv
tag_sram.sv
tag_bank_arbiter.sv
tag_hit_compare.sv
icache_tag_lookup.sv
tb_icache_tag_lookup_asserts.sv
tb_icache_tag_lookup.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the icache tag lookup testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_icache_tag_lookup \
  -f icache_tag_lookup.f --Mdir obj_dir -o tb_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
